// ==== verilog/vma_map_pkg.sv ====
/* vma map package
   map geometry, command and status codes, translation request and response types */

package vma_map_pkg;

   // level-0 map, indexed by vaddr 23..13
   localparam int L0_ADDR_W = 11;
   localparam int L0_DATA_W = 5;

   // level-1 map, indexed by {l0 entry, vaddr 12..8}
   localparam int L1_ADDR_W = 10;
   localparam int L1_DATA_W = 24;

   localparam int PPN_W   = 14;   // physical page in entry bits 13..0
   localparam int VADDR_W = 24;

   localparam int L1_ACCESS_BIT = 23;
   localparam int L1_WRITE_BIT  = 22;

   typedef enum logic [1:0] {
      OP_WR_L0,
      OP_WR_L1,
      OP_RD_L0,
      OP_RD_L1
   } map_op_t;

   typedef struct packed {
      map_op_t                op;
      logic [L0_ADDR_W-1:0]   addr;   // level-1 uses the low 10 bits
      logic [L1_DATA_W-1:0]   data;   // level-0 uses the low 5 bits
   } map_cmd_t;

   typedef enum logic [1:0] {
      XL_OK,
      XL_PAGE_FAULT,
      XL_WRITE_FAULT
   } xlate_status_t;

   typedef struct packed {
      logic [VADDR_W-1:0]   vaddr;
      logic                 write;
   } xlate_req_t;

   typedef struct packed {
      logic [PPN_W-1:0]     ppn;
      xlate_status_t        status;
   } xlate_rsp_t;

endpackage

// ==== verilog/map_dpram.sv ====
/* map dual-port RAM
   two synchronous ports on one clock, registered enable-gated reads */

module map_dpram
#(
   parameter int ADDR_WIDTH = 11,
   parameter int DATA_WIDTH = 5
)
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic [ADDR_WIDTH-1:0] address_a,
   input  logic [DATA_WIDTH-1:0] data_a,
   input  logic                  wren_a,
   input  logic                  rden_a,
   output logic [DATA_WIDTH-1:0] q_a,

   input  logic [ADDR_WIDTH-1:0] address_b,
   input  logic [DATA_WIDTH-1:0] data_b,
   input  logic                  wren_b,
   input  logic                  rden_b,
   output logic [DATA_WIDTH-1:0] q_b
);

   logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];   // contents not reset

   // both ports may write
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         mem[address_a] <= data_a;
      if (wren_b)
         mem[address_b] <= data_b;
   end

   // read before write on a shared address
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= mem[address_a];   // holds between reads
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= mem[address_b];
   end

endmodule

// ==== verilog/map_write_ctrl.sv ====
/* map command block
   registers processor map commands, drives port B of both maps, returns read-back */

module map_write_ctrl
   import vma_map_pkg::*;
(
   input  logic                 clk_a,
   input  logic                 reset,

   input  logic                 cmd_strobe,
   input  map_cmd_t             cmd,

   // level-0 map port B
   output logic [L0_ADDR_W-1:0] l0_address_b,
   output logic [L0_DATA_W-1:0] l0_data_b,
   output logic                 l0_wren_b,
   output logic                 l0_rden_b,
   input  logic [L0_DATA_W-1:0] l0_q_b,

   // level-1 map port B
   output logic [L1_ADDR_W-1:0] l1_address_b,
   output logic [L1_DATA_W-1:0] l1_data_b,
   output logic                 l1_wren_b,
   output logic                 l1_rden_b,
   input  logic [L1_DATA_W-1:0] l1_q_b,

   output logic                 rdback_valid,
   output logic [L1_DATA_W-1:0] rdback_data
);

   map_cmd_t cmd_q;
   logic     cmd_valid_q;
   logic     rd_pending_q;   // map q_b loads this cycle
   logic     rd_l1_q;        // last read went to level 1

   always_ff @(posedge clk_a)
   begin
      if (reset)
         cmd_valid_q <= 1'b0;
      else
         cmd_valid_q <= cmd_strobe;
   end

   always_ff @(posedge clk_a)
   begin
      if (cmd_strobe)
         cmd_q <= cmd;
   end

   // opcode decode into per-map enables
   assign l0_wren_b = cmd_valid_q && (cmd_q.op == OP_WR_L0);
   assign l1_wren_b = cmd_valid_q && (cmd_q.op == OP_WR_L1);
   assign l0_rden_b = cmd_valid_q && (cmd_q.op == OP_RD_L0);
   assign l1_rden_b = cmd_valid_q && (cmd_q.op == OP_RD_L1);

   assign l0_address_b = cmd_q.addr;
   assign l1_address_b = cmd_q.addr[L1_ADDR_W-1:0];
   assign l0_data_b    = cmd_q.data[L0_DATA_W-1:0];
   assign l1_data_b    = cmd_q.data;

   // remember the target map until its data is out
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_pending_q <= 1'b0;
         rd_l1_q      <= 1'b0;
      end
      else
      begin
         rd_pending_q <= l0_rden_b | l1_rden_b;
         if (l0_rden_b | l1_rden_b)
            rd_l1_q <= l1_rden_b;
      end
   end

   assign rdback_valid = rd_pending_q;

   // level-0 entries come back zero-extended
   assign rdback_data = rd_l1_q ? l1_q_b
                                : {{(L1_DATA_W-L0_DATA_W){1'b0}}, l0_q_b};

endmodule

// ==== verilog/vma_translate.sv ====
/* virtual address translation pipeline
   level-0 then level-1 map lookup on port A, access check in the last stage */

module vma_translate
   import vma_map_pkg::*;
(
   input  logic                 clk_a,
   input  logic                 reset,

   input  logic                 xlate_strobe,
   input  xlate_req_t           xlate_req,

   // level-0 map port A
   output logic [L0_ADDR_W-1:0] l0_address_a,
   output logic                 l0_rden_a,
   input  logic [L0_DATA_W-1:0] l0_q_a,

   // level-1 map port A
   output logic [L1_ADDR_W-1:0] l1_address_a,
   output logic                 l1_rden_a,
   input  logic [L1_DATA_W-1:0] l1_q_a,

   output logic                 xlate_valid,
   output xlate_rsp_t           xlate_rsp
);

   // stage 1 waits on the level-0 read
   logic                           s1_valid_q;
   logic                           s1_write_q;
   logic [L1_ADDR_W-L0_DATA_W-1:0] s1_page_q;   // vaddr 12..8

   // stage 2 waits on the level-1 read
   logic s2_valid_q;
   logic s2_write_q;

   logic access_ok;
   logic write_ok;

   // level-0 lookup straight from the request
   assign l0_address_a = xlate_req.vaddr[VADDR_W-1 -: L0_ADDR_W];
   assign l0_rden_a    = xlate_strobe;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
      end
      else
      begin
         s1_valid_q <= xlate_strobe;
         s2_valid_q <= s1_valid_q;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (xlate_strobe)
      begin
         s1_write_q <= xlate_req.write;
         s1_page_q  <= xlate_req.vaddr[VADDR_W-L0_ADDR_W-1 -: L1_ADDR_W-L0_DATA_W];
      end
      if (s1_valid_q)
         s2_write_q <= s1_write_q;
   end

   // level-1 index is the level-0 block joined with the page bits
   assign l1_address_a = {l0_q_a, s1_page_q};
   assign l1_rden_a    = s1_valid_q;

   assign access_ok = l1_q_a[L1_ACCESS_BIT];
   assign write_ok  = l1_q_a[L1_WRITE_BIT];

   always_comb
   begin
      xlate_rsp.ppn    = l1_q_a[PPN_W-1:0];
      xlate_rsp.status = XL_OK;   // idle bus reads as zero
      if (s2_valid_q)
      begin
         if (!access_ok)
            xlate_rsp.status = XL_PAGE_FAULT;
         else if (s2_write_q && !write_ok)
            xlate_rsp.status = XL_WRITE_FAULT;
      end
   end

   assign xlate_valid = s2_valid_q;   // two cycles after the strobe

endmodule

// ==== verilog/vma_map_top.sv ====
/* virtual memory map top level
   two map RAMs, the command block and the translation pipeline */

module vma_map_top
   import vma_map_pkg::*;
(
   input  logic                 clk_a,
   input  logic                 reset,

   input  logic                 xlate_strobe,
   input  xlate_req_t           xlate_req,
   output logic                 xlate_valid,
   output xlate_rsp_t           xlate_rsp,

   input  logic                 cmd_strobe,
   input  map_cmd_t             cmd,
   output logic                 rdback_valid,
   output logic [L1_DATA_W-1:0] rdback_data
);

   // port A, translation side
   logic [L0_ADDR_W-1:0] l0_address_a;
   logic                 l0_rden_a;
   logic [L0_DATA_W-1:0] l0_q_a;
   logic [L1_ADDR_W-1:0] l1_address_a;
   logic                 l1_rden_a;
   logic [L1_DATA_W-1:0] l1_q_a;

   // port B, command side
   logic [L0_ADDR_W-1:0] l0_address_b;
   logic [L0_DATA_W-1:0] l0_data_b;
   logic                 l0_wren_b;
   logic                 l0_rden_b;
   logic [L0_DATA_W-1:0] l0_q_b;
   logic [L1_ADDR_W-1:0] l1_address_b;
   logic [L1_DATA_W-1:0] l1_data_b;
   logic                 l1_wren_b;
   logic                 l1_rden_b;
   logic [L1_DATA_W-1:0] l1_q_b;

   map_dpram #(
      .ADDR_WIDTH (L0_ADDR_W),
      .DATA_WIDTH (L0_DATA_W)
   ) u_vmem0 (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l0_address_a),
      .data_a    ('0),            // translation never writes
      .wren_a    (1'b0),
      .rden_a    (l0_rden_a),
      .q_a       (l0_q_a),
      .address_b (l0_address_b),
      .data_b    (l0_data_b),
      .wren_b    (l0_wren_b),
      .rden_b    (l0_rden_b),
      .q_b       (l0_q_b)
   );

   map_dpram #(
      .ADDR_WIDTH (L1_ADDR_W),
      .DATA_WIDTH (L1_DATA_W)
   ) u_vmem1 (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l1_address_a),
      .data_a    ('0),
      .wren_a    (1'b0),
      .rden_a    (l1_rden_a),
      .q_a       (l1_q_a),
      .address_b (l1_address_b),
      .data_b    (l1_data_b),
      .wren_b    (l1_wren_b),
      .rden_b    (l1_rden_b),
      .q_b       (l1_q_b)
   );

   map_write_ctrl u_map_write_ctrl (
      .clk_a        (clk_a),
      .reset        (reset),
      .cmd_strobe   (cmd_strobe),
      .cmd          (cmd),
      .l0_address_b (l0_address_b),
      .l0_data_b    (l0_data_b),
      .l0_wren_b    (l0_wren_b),
      .l0_rden_b    (l0_rden_b),
      .l0_q_b       (l0_q_b),
      .l1_address_b (l1_address_b),
      .l1_data_b    (l1_data_b),
      .l1_wren_b    (l1_wren_b),
      .l1_rden_b    (l1_rden_b),
      .l1_q_b       (l1_q_b),
      .rdback_valid (rdback_valid),
      .rdback_data  (rdback_data)
   );

   vma_translate u_vma_translate (
      .clk_a        (clk_a),
      .reset        (reset),
      .xlate_strobe (xlate_strobe),
      .xlate_req    (xlate_req),
      .l0_address_a (l0_address_a),
      .l0_rden_a    (l0_rden_a),
      .l0_q_a       (l0_q_a),
      .l1_address_a (l1_address_a),
      .l1_rden_a    (l1_rden_a),
      .l1_q_a       (l1_q_a),
      .xlate_valid  (xlate_valid),
      .xlate_rsp    (xlate_rsp)
   );

endmodule

// ==== testbench/vma_map_properties.sv ====
/* vma map assertions
   response timing and port B enable checks, bound to the top level */

module vma_map_properties
   import vma_map_pkg::*;
(
   input logic     clk_a,
   input logic     reset,
   input logic     xlate_strobe,
   input logic     xlate_valid,
   input logic     cmd_strobe,
   input map_cmd_t cmd,
   input logic     rdback_valid,
   input logic     l0_wren_b,
   input logic     l0_rden_b,
   input logic     l1_wren_b,
   input logic     l1_rden_b
);

   logic rd_cmd;

   assign rd_cmd = cmd_strobe && (cmd.op == OP_RD_L0 || cmd.op == OP_RD_L1);

   a_xlate_latency: assert property (@(posedge clk_a) disable iff (reset)
      xlate_strobe |-> ##2 xlate_valid)
      else $error("translation response not two cycles after its strobe");

   a_xlate_source: assert property (@(posedge clk_a) disable iff (reset)
      xlate_valid |-> $past(xlate_strobe, 2))
      else $error("translation response without a strobe two cycles earlier");

   a_rdback_latency: assert property (@(posedge clk_a) disable iff (reset)
      rd_cmd |-> ##2 rdback_valid)
      else $error("read-back not two cycles after its read command");

   // port B enables one cycle after the matching command
   a_l0_port_b: assert property (@(posedge clk_a) disable iff (reset)
      (l0_wren_b == $past(cmd_strobe && cmd.op == OP_WR_L0))
      && (l0_rden_b == $past(cmd_strobe && cmd.op == OP_RD_L0)))
      else $error("level-0 port B enables do not follow the command");

   a_l1_port_b: assert property (@(posedge clk_a) disable iff (reset)
      (l1_wren_b == $past(cmd_strobe && cmd.op == OP_WR_L1))
      && (l1_rden_b == $past(cmd_strobe && cmd.op == OP_RD_L1)))
      else $error("level-1 port B enables do not follow the command");

   a_reset_idle: assert property (@(posedge clk_a) reset |=> !xlate_valid && !rdback_valid)
      else $error("output valid high during reset");

endmodule

bind vma_map_top vma_map_properties u_vma_map_properties (
   .clk_a        (clk_a),
   .reset        (reset),
   .xlate_strobe (xlate_strobe),
   .xlate_valid  (xlate_valid),
   .cmd_strobe   (cmd_strobe),
   .cmd          (cmd),
   .rdback_valid (rdback_valid),
   .l0_wren_b    (l0_wren_b),
   .l0_rden_b    (l0_rden_b),
   .l1_wren_b    (l1_wren_b),
   .l1_rden_b    (l1_rden_b)
);

// ==== testbench/vma_map_tb.sv ====
/* vma map testbench
   seeded random map commands and translations checked against a map model */

module vma_map_tb
   import vma_map_pkg::*;
();

   localparam logic [31:0] SEED = 32'hc70e6ab4;
   localparam int N_ROUNDS  = 60;
   localparam int MAX_BURST = 16;
   // a command burst may double up with read-backs
   localparam int ROUND_CYC = 2*MAX_BURST + 3 + MAX_BURST + 3;
   localparam int TOTAL_CYC = 5 + 2 + (1 << L0_ADDR_W) + (1 << L1_ADDR_W) + 3
                              + N_ROUNDS*ROUND_CYC + 4;
   localparam int TIMEOUT   = TOTAL_CYC*20 + 1000;

   logic                 clk_a;
   logic                 reset;
   logic                 xlate_strobe;
   xlate_req_t           xlate_req;
   logic                 xlate_valid;
   xlate_rsp_t           xlate_rsp;
   logic                 cmd_strobe;
   map_cmd_t             cmd;
   logic                 rdback_valid;
   logic [L1_DATA_W-1:0] rdback_data;

   // reference copies of both maps
   logic [L0_DATA_W-1:0] l0_model [0:(1 << L0_ADDR_W)-1];
   logic [L1_DATA_W-1:0] l1_model [0:(1 << L1_ADDR_W)-1];

   xlate_rsp_t           xq_rsp [$];
   int                   xq_cyc [$];    // cycle the response is due
   logic [L1_DATA_W-1:0] rq_data [$];
   int                   rq_cyc [$];

   int                   cyc = 0;
   bit                   started = 1'b0;   // set by the first strobe
   int                   xlate_errs = 0;
   int                   rdback_errs = 0;
   int                   other_errs = 0;
   logic [L0_ADDR_W-1:0] last_l0_addr;
   logic [L1_ADDR_W-1:0] last_l1_addr;

   vma_map_top u_vma_map_top (
      .clk_a        (clk_a),
      .reset        (reset),
      .xlate_strobe (xlate_strobe),
      .xlate_req    (xlate_req),
      .xlate_valid  (xlate_valid),
      .xlate_rsp    (xlate_rsp),
      .cmd_strobe   (cmd_strobe),
      .cmd          (cmd),
      .rdback_valid (rdback_valid),
      .rdback_data  (rdback_data)
   );

   always #10 clk_a = ~clk_a;

   always @(posedge clk_a)
      cyc <= cyc + 1;

   // status rule applied to the model entries
   function automatic xlate_rsp_t expect_xlate(xlate_req_t req);
      logic [L0_DATA_W-1:0] blk;
      logic [L1_DATA_W-1:0] ent;
      xlate_rsp_t           rsp;
      blk = l0_model[req.vaddr[23:13]];
      ent = l1_model[{blk, req.vaddr[12:8]}];
      rsp.ppn = ent[PPN_W-1:0];
      if (!ent[L1_ACCESS_BIT])
         rsp.status = XL_PAGE_FAULT;
      else if (req.write && !ent[L1_WRITE_BIT])
         rsp.status = XL_WRITE_FAULT;
      else
         rsp.status = XL_OK;
      return rsp;
   endfunction

   // first level-0 slot pointing at a given block, -1 if none
   function automatic int find_l0_index(logic [L0_DATA_W-1:0] blk);
      for (int i = 0; i < (1 << L0_ADDR_W); i++)
         if (l0_model[i[L0_ADDR_W-1:0]] == blk)
            return i;
      return -1;
   endfunction

   task automatic next_cycle();
      @(posedge clk_a);
      #1;
      cmd_strobe   = 1'b0;
      xlate_strobe = 1'b0;
   endtask

   task automatic idle_cycles(int n);
      repeat (n) next_cycle();
   endtask

   task automatic issue_cmd(map_op_t op, logic [L0_ADDR_W-1:0] addr,
                            logic [L1_DATA_W-1:0] data);
      next_cycle();
      cmd_strobe = 1'b1;
      cmd.op     = op;
      cmd.addr   = addr;
      cmd.data   = data;
      started    = 1'b1;
      if (op == OP_WR_L0)
      begin
         l0_model[addr] = data[L0_DATA_W-1:0];
         last_l0_addr   = addr;
      end
      else if (op == OP_WR_L1)
      begin
         l1_model[addr[L1_ADDR_W-1:0]] = data;
         last_l1_addr = addr[L1_ADDR_W-1:0];
      end
      else
      begin
         if (op == OP_RD_L0)
            rq_data.push_back({{(L1_DATA_W-L0_DATA_W){1'b0}}, l0_model[addr]});
         else
            rq_data.push_back(l1_model[addr[L1_ADDR_W-1:0]]);
         rq_cyc.push_back(cyc + 2);
      end
   endtask

   task automatic issue_xlate(xlate_req_t req);
      next_cycle();
      xlate_strobe = 1'b1;
      xlate_req    = req;
      started      = 1'b1;
      xq_rsp.push_back(expect_xlate(req));
      xq_cyc.push_back(cyc + 2);
   endtask

   task automatic cmd_burst();
      logic [31:0]          r;
      logic [31:0]          d;
      int                   n;
      map_op_t              op;
      logic [L0_ADDR_W-1:0] addr;
      r = $urandom;
      n = int'(r[3:0]) + 1;
      for (int i = 0; i < n; i++)
      begin
         r    = $urandom;
         d    = $urandom;
         op   = map_op_t'(r[1:0]);
         addr = r[12:2];
         issue_cmd(op, addr, d[L1_DATA_W-1:0]);
         // read straight back after some writes
         if (r[13] && op == OP_WR_L0)
            issue_cmd(OP_RD_L0, addr, '0);
         else if (r[13] && op == OP_WR_L1)
            issue_cmd(OP_RD_L1, addr, '0);
      end
   endtask

   task automatic xlate_burst();
      logic [31:0] r;
      int          n;
      int          idx;
      xlate_req_t  req;
      r = $urandom;
      n = int'(r[3:0]) + 1;
      for (int i = 0; i < n; i++)
      begin
         r         = $urandom;
         req.vaddr = r[23:0];
         req.write = r[24];
         if (r[27:26] == 2'd0)
            req.vaddr[23:13] = last_l0_addr;   // through the latest level-0 write
         else if (r[27:26] == 2'd1)
         begin
            idx = find_l0_index(last_l1_addr[9:5]);
            if (idx >= 0)
            begin
               req.vaddr[23:13] = idx[L0_ADDR_W-1:0];
               req.vaddr[12:8]  = last_l1_addr[4:0];
            end
         end
         issue_xlate(req);
      end
   endtask

   task automatic check_xlate();
      xlate_rsp_t exp_rsp;
      int         exp_cyc;
      if (xlate_valid)
      begin
         if (xq_cyc.size() == 0)
         begin
            other_errs++;
            $display("Error: translation response with no request outstanding");
         end
         else
         begin
            exp_rsp = xq_rsp.pop_front();
            exp_cyc = xq_cyc.pop_front();
            if (exp_cyc != cyc)
            begin
               xlate_errs++;
               $display("Fail xlate_latency: expected cycle %0d actual cycle %0d", exp_cyc, cyc);
            end
            if (xlate_rsp != exp_rsp)
            begin
               xlate_errs++;
               $display("Fail xlate_rsp: expected %h actual %h", exp_rsp, xlate_rsp);
            end
         end
      end
      else if (xq_cyc.size() != 0 && xq_cyc[0] <= cyc)
      begin
         other_errs++;
         $display("Error: translation response missing in cycle %0d", cyc);
         void'(xq_rsp.pop_front());
         void'(xq_cyc.pop_front());
      end
   endtask

   task automatic check_rdback();
      logic [L1_DATA_W-1:0] exp_data;
      int                   exp_cyc;
      if (rdback_valid)
      begin
         if (rq_cyc.size() == 0)
         begin
            other_errs++;
            $display("Error: read-back data with no read outstanding");
         end
         else
         begin
            exp_data = rq_data.pop_front();
            exp_cyc  = rq_cyc.pop_front();
            if (exp_cyc != cyc)
            begin
               rdback_errs++;
               $display("Fail rdback_latency: expected cycle %0d actual cycle %0d", exp_cyc, cyc);
            end
            if (rdback_data != exp_data)
            begin
               rdback_errs++;
               $display("Fail rdback_data: expected %h actual %h", exp_data, rdback_data);
            end
         end
      end
      else if (rq_cyc.size() != 0 && rq_cyc[0] <= cyc)
      begin
         other_errs++;
         $display("Error: read-back data missing in cycle %0d", cyc);
         void'(rq_data.pop_front());
         void'(rq_cyc.pop_front());
      end
   endtask

   // outputs are sampled mid-cycle
   always @(negedge clk_a)
   begin
      if (reset)
      begin
         if (xlate_valid || rdback_valid)
         begin
            other_errs++;
            $display("Error: an output valid is high during reset");
         end
      end
      else
      begin
         if (!started && (xlate_valid || rdback_valid || xlate_rsp != '0 || rdback_data != '0))
         begin
            other_errs++;
            $display("Error: outputs not idle after reset before the first strobe");
         end
         check_xlate();
         check_rdback();
      end
   end

   initial
   begin
      logic [31:0] r;
      r            = $urandom(SEED);
      clk_a        = 1'b0;
      reset        = 1'b1;
      xlate_strobe = 1'b0;
      xlate_req    = '0;
      cmd_strobe   = 1'b0;
      cmd          = '0;
      repeat (5) @(posedge clk_a);
      #1;
      reset = 1'b0;
      idle_cycles(2);

      // fill both maps completely
      for (int i = 0; i < (1 << L0_ADDR_W); i++)
      begin
         r = $urandom;
         issue_cmd(OP_WR_L0, i[L0_ADDR_W-1:0], r[L1_DATA_W-1:0]);
      end
      for (int i = 0; i < (1 << L1_ADDR_W); i++)
      begin
         r = $urandom;
         issue_cmd(OP_WR_L1, {1'b0, i[L1_ADDR_W-1:0]}, r[L1_DATA_W-1:0]);
      end
      idle_cycles(3);

      for (int k = 0; k < N_ROUNDS; k++)
      begin
         cmd_burst();
         idle_cycles(3);   // keeps translations clear of pending writes
         xlate_burst();
         idle_cycles(3);
      end
      idle_cycles(4);

      if (xq_cyc.size() != 0 || rq_cyc.size() != 0)
      begin
         other_errs++;
         $display("Error: responses still outstanding at the end of the run");
      end
      $display("errors: xlate %0d rdback %0d other %0d", xlate_errs, rdback_errs, other_errs);
      if (xlate_errs + rdback_errs + other_errs == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      #(TIMEOUT);
      $display("Error: watchdog expired before the tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== vma_map_top.f ====
verilog/vma_map_pkg.sv
verilog/map_dpram.sv
verilog/map_write_ctrl.sv
verilog/vma_translate.sv
verilog/vma_map_top.sv
testbench/vma_map_properties.sv
testbench/vma_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vma map testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vma_map_tb -Mdir obj_dir -f vma_map_top.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vvma_map_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
